//--- bench/ldu_stimulus.txt
# op imm src(0 reg 1 bus 2 fast) bank_or_pipe cq operand delay
# expected: vpn word_offset byte_mask misaligned request_count (hex except delay, count)
2 004 0 0 0 10000000 0 10000 001 f 0 1
0 003 2 0 1 20000010 0 20000 004 8 0 1
1 002 1 1 2 30000100 0 30000 040 c 0 1
5 7ff 2 1 3 00001000 3 00001 1ff 8 1 2
2 ffc 0 0 4 40000008 2 40000 001 f 0 1
4 001 2 2 5 50000020 1 50000 008 2 0 1
2 001 1 2 6 60000000 0 60000 000 e 1 2
1 000 2 3 7 70000ffe 4 70000 3ff c 0 1
2 002 0 0 0 00002ffc 5 00002 3ff c 1 2
0 fff 2 0 1 80000001 0 80000 000 1 0 1
2 010 1 3 2 90000020 0 90000 00c f 0 1
1 001 2 1 3 a0000000 2 a0000 000 6 0 1
5 003 0 0 4 b0000004 1 b0000 001 8 1 2
2 100 2 2 5 c0000000 0 c0000 040 f 0 1
4 005 1 0 6 d0000010 0 d0000 005 2 0 1
2 003 2 3 7 e0000000 3 e0000 000 8 1 2
1 800 0 0 0 00010800 0 00010 000 3 0 1
2 008 2 0 1 f0000000 6 f0000 002 f 0 1
0 002 1 1 2 12345670 0 12345 19c 4 0 1
3 000 2 1 3 23456788 1 23456 1e2 f 0 1

//--- sim.f
+incdir+common
common/system_types_pkg.sv
common/core_types_pkg.sv
ldu/ldu_issue_decode.sv
ldu/ldu_agen.sv
ldu/ldu_req_stage.sv
ldu/ldu_addr_pipeline.sv
verilog/ldu_addr_pipeline_wrapper.sv
bench/tb_ldu_addr_pipeline.sv

//--- run_sim.sh
#!/bin/sh
# build and run the load address pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module tb_ldu_addr_pipeline; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_ldu_addr_pipeline 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
fi

if echo "$output" | grep -q "Testbench passed"; then
	exit 0
fi
exit 1

//--- bench/tb_ldu_addr_pipeline.sv
// --------------------------------------------------
// load address pipeline testbench
// replays loads from the stimulus file, serves the
// operand sources and checks every cache request
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

module tb_ldu_addr_pipeline;
	timeunit 1ns;
	timeprecision 100ps;

	import core_types_pkg::*;
	import system_types_pkg::*;

	localparam int MAX_OPS = 64;

	logic CLK;
	logic nRST;
	logic next_issue_valid;
	ldu_issue_t next_issue;
	logic last_issue_ready;
	logic next_A_reg_read_resp_valid;
	logic [31:0] next_A_reg_read_resp_data;
	logic [`PRF_BANK_COUNT-1:0][31:0] next_bus_forward_data_by_bank;
	logic [3:0] next_fast_forward_data_valid_by_pipe;
	logic [3:0][31:0] next_fast_forward_data_by_pipe;
	logic last_REQ_bank0_valid;
	logic last_REQ_bank1_valid;
	ldu_req_t last_REQ;
	logic next_REQ_bank0_early_ready;
	logic next_REQ_bank1_early_ready;

	// stimulus columns
	logic [3:0] op_code [MAX_OPS];
	logic [11:0] imm [MAX_OPS];
	logic [1:0] src [MAX_OPS];
	logic [1:0] sel [MAX_OPS];
	logic [2:0] cq [MAX_OPS];
	logic [31:0] operand [MAX_OPS];
	int delay [MAX_OPS];
	logic [19:0] exp_vpn [MAX_OPS];
	logic [9:0] exp_word [MAX_OPS];
	logic [3:0] exp_mask [MAX_OPS];
	logic exp_mis [MAX_OPS];
	int exp_count [MAX_OPS];
	int n_ops = 0;

	// run state
	int cyc;
	int issued;
	int served;
	int ops_started;
	int bus_idx;
	int issue_cyc [MAX_OPS];
	logic srv_active;
	ldu_req_t exp_q [$];
	logic held_valid;
	logic [40:0] held_val;
	logic rdy0_d1;
	logic rdy0_d2;
	logic rdy1_d1;
	logic rdy1_d2;
	logic saw_ready_low;
	logic [15:0] lfsr;

	ldu_addr_pipeline_wrapper i_dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_issue_valid(next_issue_valid),
		.next_issue(next_issue),
		.last_issue_ready(last_issue_ready),
		.next_A_reg_read_resp_valid(next_A_reg_read_resp_valid),
		.next_A_reg_read_resp_data(next_A_reg_read_resp_data),
		.next_bus_forward_data_by_bank(next_bus_forward_data_by_bank),
		.next_fast_forward_data_valid_by_pipe(next_fast_forward_data_valid_by_pipe),
		.next_fast_forward_data_by_pipe(next_fast_forward_data_by_pipe),
		.last_REQ_bank0_valid(last_REQ_bank0_valid),
		.last_REQ_bank1_valid(last_REQ_bank1_valid),
		.last_REQ(last_REQ),
		.next_REQ_bank0_early_ready(next_REQ_bank0_early_ready),
		.next_REQ_bank1_early_ready(next_REQ_bank1_early_ready)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// --------------------------------------------------
	// helpers

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	task automatic load_stimulus();
		int fd;
		int nf;
		int r;
		string line;
		fd = $fopen("bench/ldu_stimulus.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the stimulus file");
		end
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
				nf = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %d",
					op_code[n_ops], imm[n_ops], src[n_ops], sel[n_ops], cq[n_ops],
					operand[n_ops], delay[n_ops], exp_vpn[n_ops], exp_word[n_ops],
					exp_mask[n_ops], exp_mis[n_ops], exp_count[n_ops]);
				if (nf == 12) begin
					n_ops++;
				end
			end
		end
		$fclose(fd);
		if (n_ops == 0) begin
			fail_run("the stimulus file holds no loads");
		end
	endtask

	// expected requests from the address rule, first one checked against the file
	task automatic push_expected(input int i);
		logic [31:0] addr;
		int size_bytes;
		int spill;
		ldu_req_t r;
		addr = operand[i] + {{20{imm[i][11]}}, imm[i]};
		case (op_code[i])
			4'h0, 4'h4: size_bytes = 1;
			4'h1, 4'h5: size_bytes = 2;
			default: size_bytes = 4;
		endcase
		// bytes that run past the end of the first word
		spill = int'(addr[1:0]) + size_bytes - 4;
		check_value("file word address", {exp_vpn[i], exp_word[i]}, addr[31:2]);
		check_value("file request count", exp_count[i], (spill > 0) ? 2 : 1);
		check_value("file misaligned flag", exp_mis[i], spill > 0);
		r.is_mq = 1'b0;
		r.misaligned = exp_mis[i];
		r.vpn = exp_vpn[i];
		r.po_word = exp_word[i];
		r.byte_mask = exp_mask[i];
		r.cq_index = cq[i];
		exp_q.push_back(r);
		if (spill > 0) begin
			r.is_mq = 1'b1;
			{r.vpn, r.po_word} = addr[31:2] + 30'd1;
			r.byte_mask = 4'((1 << spill) - 1);
			exp_q.push_back(r);
		end
	endtask

	task automatic check_reset_outputs();
		check_value("last_issue_ready", last_issue_ready, 0);
		check_value("last_REQ_bank0_valid", last_REQ_bank0_valid, 0);
		check_value("last_REQ_bank1_valid", last_REQ_bank1_valid, 0);
		check_value("last_REQ", last_REQ, 0);
	endtask

	// --------------------------------------------------
	// output monitor

	// request seen now was accepted by ready driven two falling edges ago
	task automatic sample_outputs();
		logic [40:0] cur;
		logic acc;
		ldu_req_t e;
		cur = {last_REQ_bank0_valid, last_REQ_bank1_valid, last_REQ};
		acc = (last_REQ_bank0_valid & rdy0_d2) | (last_REQ_bank1_valid & rdy1_d2);
		if (!last_issue_ready) begin
			saw_ready_low = 1'b1;
		end
		if (last_REQ_bank0_valid | last_REQ_bank1_valid) begin
			if (held_valid) begin
				check_value("held request", cur, held_val);
			end else begin
				if (exp_q.size() == 0) begin
					fail_run("a request came out with no load pending");
				end
				e = exp_q.pop_front();
				check_value("last_REQ.is_mq", last_REQ.is_mq, e.is_mq);
				check_value("last_REQ.misaligned", last_REQ.misaligned, e.misaligned);
				check_value("last_REQ.vpn", last_REQ.vpn, e.vpn);
				check_value("last_REQ.po_word", last_REQ.po_word, e.po_word);
				check_value("last_REQ.byte_mask", last_REQ.byte_mask, e.byte_mask);
				check_value("last_REQ.cq_index", last_REQ.cq_index, e.cq_index);
				check_value("last_REQ_bank0_valid", last_REQ_bank0_valid, !e.po_word[0]);
				check_value("last_REQ_bank1_valid", last_REQ_bank1_valid, e.po_word[0]);
				if (!e.is_mq) begin
					ops_started++;
				end
			end
			held_valid = !acc;
			held_val = cur;
		end else begin
			if (held_valid) begin
				fail_run("a request vanished while its bank was not ready");
			end
			held_valid = 1'b0;
		end
	endtask

	// --------------------------------------------------
	// input driver

	task automatic drive_inputs();
		logic b;
		logic r0;
		logic r1;
		// each bank ready one time in four
		take_bit(b);
		r0 = b;
		take_bit(b);
		r0 = r0 & b;
		take_bit(b);
		r1 = b;
		take_bit(b);
		r1 = r1 & b;
		rdy0_d2 = rdy0_d1;
		rdy0_d1 = r0;
		rdy1_d2 = rdy1_d1;
		rdy1_d1 = r1;
		next_REQ_bank0_early_ready = r0;
		next_REQ_bank1_early_ready = r1;

		// bus carries junk except the cycle after a bus op issues
		for (int k = 0; k < `PRF_BANK_COUNT; k++) begin
			next_bus_forward_data_by_bank[k] = {12'hbad, 4'(k), 16'(cyc)};
		end
		if (bus_idx >= 0) begin
			next_bus_forward_data_by_bank[sel[bus_idx]] = operand[bus_idx];
			bus_idx = -1;
		end

		next_issue_valid = 1'b0;
		if (last_issue_ready && issued < n_ops) begin
			next_issue.op = ldu_op_t'(op_code[issued]);
			next_issue.imm12 = imm[issued];
			next_issue.src = op_src_t'(src[issued]);
			next_issue.pipe = sel[issued];
			next_issue.bank = sel[issued];
			next_issue.cq_index = cq[issued];
			next_issue_valid = 1'b1;
			push_expected(issued);
			issue_cyc[issued] = cyc;
			if (src[issued] == 2'd1) begin
				bus_idx = issued;
			end
			issued++;
		end

		// register and fast-forward operands, one op at a time in issue order
		if (srv_active) begin
			if (ops_started > served) begin
				srv_active = 1'b0;
				served++;
				next_A_reg_read_resp_valid = 1'b0;
				next_fast_forward_data_valid_by_pipe = '0;
			end
		end else if (served < issued) begin
			if (src[served] == 2'd1) begin
				served++;
			end else if (cyc >= issue_cyc[served] + 1 + delay[served]) begin
				srv_active = 1'b1;
				if (src[served] == 2'd0) begin
					next_A_reg_read_resp_valid = 1'b1;
					next_A_reg_read_resp_data = operand[served];
				end else begin
					next_fast_forward_data_valid_by_pipe[sel[served]] = 1'b1;
					next_fast_forward_data_by_pipe[sel[served]] = operand[served];
				end
			end
		end
		cyc++;
	endtask

	// --------------------------------------------------
	// main sequence

	initial begin
		nRST = 1'b0;
		next_issue_valid = 1'b0;
		next_issue = '0;
		next_A_reg_read_resp_valid = 1'b0;
		next_A_reg_read_resp_data = '0;
		next_bus_forward_data_by_bank = '0;
		next_fast_forward_data_valid_by_pipe = '0;
		next_fast_forward_data_by_pipe = '0;
		next_REQ_bank0_early_ready = 1'b0;
		next_REQ_bank1_early_ready = 1'b0;
		cyc = 0;
		issued = 0;
		served = 0;
		ops_started = 0;
		bus_idx = -1;
		srv_active = 1'b0;
		held_valid = 1'b0;
		held_val = '0;
		rdy0_d1 = 1'b0;
		rdy0_d2 = 1'b0;
		rdy1_d1 = 1'b0;
		rdy1_d2 = 1'b0;
		saw_ready_low = 1'b0;
		lfsr = 16'd12954;

		load_stimulus();

		repeat (10) begin
			@(negedge CLK);
			check_reset_outputs();
		end
		nRST = 1'b1;

		while (!last_issue_ready) begin
			@(negedge CLK);
		end

		while (issued < n_ops || exp_q.size() > 0 || held_valid) begin
			@(negedge CLK);
			sample_outputs();
			drive_inputs();
		end

		// buffer drains, ready comes back and nothing more is requested
		while (!last_issue_ready) begin
			@(negedge CLK);
			sample_outputs();
			drive_inputs();
		end
		repeat (5) begin
			@(negedge CLK);
			sample_outputs();
			drive_inputs();
		end

		if (saw_ready_low) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_run("issue ready never fell under bank back-pressure");
		end
	end

	// watchdog, 40 cycles per load plus reset
	initial begin
		wait (n_ops > 0);
		repeat (n_ops * 40 + 40) @(posedge CLK);
		$display("timeout: the loads did not finish in time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- verilog/ldu_addr_pipeline_wrapper.sv
// --------------------------------------------------
// load address pipeline top level
// one register stage on every input and output
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

module ldu_addr_pipeline_wrapper #(
	parameter int IS_OC_BUFFER_SIZE = 2,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,

	// issue queue
	input logic next_issue_valid,
	input core_types_pkg::ldu_issue_t next_issue,
	output logic last_issue_ready,

	// register read response
	input logic next_A_reg_read_resp_valid,
	input logic [31:0] next_A_reg_read_resp_data,

	// forwarding
	input logic [`PRF_BANK_COUNT-1:0][31:0] next_bus_forward_data_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] next_fast_forward_data_valid_by_pipe,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0] next_fast_forward_data_by_pipe,

	// data cache requests
	output logic last_REQ_bank0_valid,
	output logic last_REQ_bank1_valid,
	output system_types_pkg::ldu_req_t last_REQ,

	input logic next_REQ_bank0_early_ready,
	input logic next_REQ_bank1_early_ready
);
	import core_types_pkg::*;
	import system_types_pkg::*;

	logic issue_valid;
	ldu_issue_t issue;
	logic issue_ready;
	logic A_reg_read_resp_valid;
	logic [31:0] A_reg_read_resp_data;
	logic [`PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank;
	logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe;
	logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe;
	logic REQ_bank0_valid;
	logic REQ_bank1_valid;
	ldu_req_t REQ;
	logic REQ_bank0_early_ready;
	logic REQ_bank1_early_ready;

	ldu_addr_pipeline #(
		.IS_OC_BUFFER_SIZE(IS_OC_BUFFER_SIZE),
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) u_pipeline (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_resp_valid(A_reg_read_resp_valid),
		.A_reg_read_resp_data(A_reg_read_resp_data),
		.bus_forward_data_by_bank(bus_forward_data_by_bank),
		.fast_forward_data_valid_by_pipe(fast_forward_data_valid_by_pipe),
		.fast_forward_data_by_pipe(fast_forward_data_by_pipe),
		.REQ_bank0_valid(REQ_bank0_valid),
		.REQ_bank1_valid(REQ_bank1_valid),
		.REQ(REQ),
		.REQ_bank0_early_ready(REQ_bank0_early_ready),
		.REQ_bank1_early_ready(REQ_bank1_early_ready)
	);

	// --------------------------------------------------
	// boundary registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
			issue <= '0;
			A_reg_read_resp_valid <= 1'b0;
			A_reg_read_resp_data <= '0;
			bus_forward_data_by_bank <= '0;
			fast_forward_data_valid_by_pipe <= '0;
			fast_forward_data_by_pipe <= '0;
			REQ_bank0_early_ready <= 1'b0;
			REQ_bank1_early_ready <= 1'b0;

			last_issue_ready <= 1'b0;
			last_REQ_bank0_valid <= 1'b0;
			last_REQ_bank1_valid <= 1'b0;
			last_REQ <= '0;
		end else begin
			// inputs
			issue_valid <= next_issue_valid;
			issue <= next_issue;
			A_reg_read_resp_valid <= next_A_reg_read_resp_valid;
			A_reg_read_resp_data <= next_A_reg_read_resp_data;
			bus_forward_data_by_bank <= next_bus_forward_data_by_bank;
			fast_forward_data_valid_by_pipe <= next_fast_forward_data_valid_by_pipe;
			fast_forward_data_by_pipe <= next_fast_forward_data_by_pipe;
			REQ_bank0_early_ready <= next_REQ_bank0_early_ready;
			REQ_bank1_early_ready <= next_REQ_bank1_early_ready;

			// outputs
			last_issue_ready <= issue_ready;
			last_REQ_bank0_valid <= REQ_bank0_valid;
			last_REQ_bank1_valid <= REQ_bank1_valid;
			last_REQ <= REQ;
		end
	end

endmodule

`default_nettype wire

//--- ldu/ldu_addr_pipeline.sv
// --------------------------------------------------
// load address pipeline
// operand collector buffer in front of address
// generation and the cache request stage
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

module ldu_addr_pipeline #(
	parameter int IS_OC_BUFFER_SIZE = 2,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,

	input logic issue_valid,
	input core_types_pkg::ldu_issue_t issue,
	output logic issue_ready,

	input logic A_reg_read_resp_valid,
	input logic [31:0] A_reg_read_resp_data,

	input logic [`PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe,

	output logic REQ_bank0_valid,
	output logic REQ_bank1_valid,
	output system_types_pkg::ldu_req_t REQ,

	input logic REQ_bank0_early_ready,
	input logic REQ_bank1_early_ready
);
	import core_types_pkg::*;
	import system_types_pkg::*;

	localparam int OC_ENTRIES = IS_OC_BUFFER_SIZE + 1;
	localparam int PTR_W = $clog2(OC_ENTRIES);
	localparam int CNT_W = $clog2(OC_ENTRIES + 1);

	ldu_decoded_t issue_decoded;
	ldu_decoded_t oc_op [OC_ENTRIES];
	logic [31:0] oc_bus_data [OC_ENTRIES];
	logic [OC_ENTRIES-1:0] oc_bus_saved;

	logic [PTR_W-1:0] head_ptr;
	logic [PTR_W-1:0] tail_ptr;
	logic [PTR_W-1:0] last_wr_ptr;
	logic last_wr_valid;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	logic head_present;
	logic head_first_cycle;
	logic [`PRF_BANK_COUNT-1:0][31:0] agen_bus_data;
	logic operand_ready;
	logic stage_busy;
	logic pop;
	ldu_vaddr_t agen_vaddr;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		nxt = ptr + PTR_W'(1);
		if (ptr == PTR_W'(OC_ENTRIES - 1)) begin
			nxt = '0;
		end
		return nxt;
	endfunction

	ldu_issue_decode u_decode (
		.issue(issue),
		.decoded(issue_decoded)
	);

	// --------------------------------------------------
	// operand collector

	assign head_present = (count != '0);
	assign head_first_cycle = last_wr_valid & (last_wr_ptr == head_ptr);

	// a bus op stuck behind an older op uses the value captured on arrival
	assign agen_bus_data = oc_bus_saved[head_ptr] ?
		{`PRF_BANK_COUNT{oc_bus_data[head_ptr]}} : bus_forward_data_by_bank;

	assign pop = operand_ready & ~stage_busy;
	assign count_next = count + CNT_W'(issue_valid) - CNT_W'(pop);

	// two spare entries cover ops already in flight from the issue queue
	assign issue_ready = (CNT_W'(OC_ENTRIES) - count_next) >= CNT_W'(2);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
			last_wr_valid <= 1'b0;
			last_wr_ptr <= '0;
			oc_bus_saved <= '0;
		end else begin
			count <= count_next;
			last_wr_valid <= issue_valid;
			if (issue_valid) begin
				tail_ptr <= ptr_inc(tail_ptr);
				last_wr_ptr <= tail_ptr;
				oc_bus_saved[tail_ptr] <= 1'b0;
			end
			if (pop) begin
				head_ptr <= ptr_inc(head_ptr);
			end
			if (last_wr_valid) begin
				oc_bus_saved[last_wr_ptr] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (issue_valid) begin
			oc_op[tail_ptr] <= issue_decoded;
		end
		if (last_wr_valid) begin
			oc_bus_data[last_wr_ptr] <= bus_forward_data_by_bank[oc_op[last_wr_ptr].bank];
		end
	end

	// --------------------------------------------------
	// execute and result

	ldu_agen #(
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) u_agen (
		.op(oc_op[head_ptr]),
		.op_present(head_present),
		.reg_resp_valid(A_reg_read_resp_valid),
		.reg_resp_data(A_reg_read_resp_data),
		.bus_forward_data_by_bank(agen_bus_data),
		.fast_forward_data_valid_by_pipe(fast_forward_data_valid_by_pipe),
		.fast_forward_data_by_pipe(fast_forward_data_by_pipe),
		.first_cycle(head_first_cycle | oc_bus_saved[head_ptr]),
		.operand_ready(operand_ready),
		.vaddr(agen_vaddr)
	);

	ldu_req_stage u_req (
		.CLK(CLK),
		.nRST(nRST),
		.load_valid(pop),
		.load_vaddr(agen_vaddr),
		.load_op(oc_op[head_ptr]),
		.busy(stage_busy),
		.req(REQ),
		.bank0_valid(REQ_bank0_valid),
		.bank1_valid(REQ_bank1_valid),
		.bank0_early_ready(REQ_bank0_early_ready),
		.bank1_early_ready(REQ_bank1_early_ready)
	);

endmodule

`default_nettype wire

//--- ldu/ldu_req_stage.sv
// --------------------------------------------------
// load request stage
// builds bank requests and byte masks, splits word
// crossing loads in two and holds under back-pressure
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

module ldu_req_stage (
	input logic CLK,
	input logic nRST,

	input logic load_valid,
	input system_types_pkg::ldu_vaddr_t load_vaddr,
	input core_types_pkg::ldu_decoded_t load_op,
	output logic busy,

	output system_types_pkg::ldu_req_t req,
	output logic bank0_valid,
	output logic bank1_valid,

	input logic bank0_early_ready,
	input logic bank1_early_ready
);
	import system_types_pkg::*;

	localparam int WORD_ADDR_W = `VPN_WIDTH + `PO_WIDTH - 2;

	typedef enum logic {
		REQ_FIRST,
		REQ_SECOND
	} req_state_t;

	req_state_t state;
	logic valid;
	logic [3:0] mask_hi;

	logic [3:0] base_mask;
	logic [7:0] span_mask;
	logic bank_ready;
	logic accept;
	logic last_of_load;
	logic take;
	logic [WORD_ADDR_W-1:0] next_word;

	// --------------------------------------------------
	// mask and handshake

	always_comb begin
		case (load_op.size)
			3'd1: begin
				base_mask = 4'b0001;
			end
			3'd2: begin
				base_mask = 4'b0011;
			end
			default: begin
				base_mask = 4'b1111;
			end
		endcase
	end

	// upper nibble is what spills into the next word
	assign span_mask = {4'b0000, base_mask} << load_vaddr.byte_offset;

	// word offset bit 0 picks the bank
	assign bank_ready = req.po_word[0] ? bank1_early_ready : bank0_early_ready;
	assign accept = valid & bank_ready;
	assign last_of_load = (state == REQ_SECOND) | ~req.misaligned;
	assign busy = valid & ~(accept & last_of_load);
	assign take = load_valid & ~busy;

	assign bank0_valid = valid & ~req.po_word[0];
	assign bank1_valid = valid & req.po_word[0];

	// carries into the VPN on a page crossing
	assign next_word = {req.vpn, req.po_word} + WORD_ADDR_W'(1);

	// --------------------------------------------------
	// FSM

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid <= 1'b0;
			state <= REQ_FIRST;
		end else if (take) begin
			valid <= 1'b1;
			state <= REQ_FIRST;
		end else if (accept) begin
			if (last_of_load) begin
				valid <= 1'b0;
				state <= REQ_FIRST;
			end else begin
				state <= REQ_SECOND;
			end
		end
	end

	// request payload
	always_ff @(posedge CLK) begin
		if (take) begin
			req.is_mq <= 1'b0;
			req.misaligned <= |span_mask[7:4];
			req.vpn <= load_vaddr.vpn;
			req.po_word <= load_vaddr.po_word;
			req.byte_mask <= span_mask[3:0];
			req.cq_index <= load_op.cq_index;
			mask_hi <= span_mask[7:4];
		end else if (accept & ~last_of_load) begin
			// second half goes to the misaligned queue
			req.is_mq <= 1'b1;
			{req.vpn, req.po_word} <= next_word;
			req.byte_mask <= mask_hi;
		end
	end

endmodule

`default_nettype wire

//--- ldu/ldu_agen.sv
// --------------------------------------------------
// load address generation
// picks operand A for the head op and adds the
// sign-extended immediate
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

module ldu_agen #(
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input core_types_pkg::ldu_decoded_t op,
	input logic op_present,

	input logic reg_resp_valid,
	input logic [31:0] reg_resp_data,

	input logic [`PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank,

	input logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe,

	input logic first_cycle,

	output logic operand_ready,
	output system_types_pkg::ldu_vaddr_t vaddr
);
	import core_types_pkg::*;
	import system_types_pkg::*;

	logic [31:0] operand;
	logic operand_avail;
	logic [31:0] imm_sext;

	// --------------------------------------------------
	// operand select

	always_comb begin
		operand = reg_resp_data;
		operand_avail = reg_resp_valid;
		case (op.src)
			SRC_BUS: begin
				// bus value only stands for one cycle
				operand = bus_forward_data_by_bank[op.bank];
				operand_avail = first_cycle;
			end
			SRC_FAST: begin
				operand = fast_forward_data_by_pipe[op.pipe];
				operand_avail = fast_forward_data_valid_by_pipe[op.pipe];
			end
			default: begin
				operand = reg_resp_data;
				operand_avail = reg_resp_valid;
			end
		endcase
	end

	assign operand_ready = op_present & operand_avail;

	// --------------------------------------------------
	// address add

	assign imm_sext = {{20{op.imm12[11]}}, op.imm12};
	assign vaddr = ldu_vaddr_t'(operand + imm_sext);

endmodule

`default_nettype wire

//--- ldu/ldu_issue_decode.sv
// --------------------------------------------------
// load issue decode
// turns an issued load into access size plus the
// fields the operand collector keeps
// --------------------------------------------------

`default_nettype none

module ldu_issue_decode (
	input core_types_pkg::ldu_issue_t issue,
	output core_types_pkg::ldu_decoded_t decoded
);
	import core_types_pkg::*;

	always_comb begin
		decoded.src = issue.src;
		decoded.pipe = issue.pipe;
		decoded.bank = issue.bank;
		decoded.imm12 = issue.imm12;
		decoded.cq_index = issue.cq_index;

		// signedness only matters on data return
		case (issue.op)
			LB, LBU: begin
				decoded.size = 3'd1;
			end
			LH, LHU: begin
				decoded.size = 3'd2;
			end
			// LW and any unknown code
			default: begin
				decoded.size = 3'd4;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- common/core_types_pkg.sv
// --------------------------------------------------
// core types
// load op codes, operand sources and the issued
// and decoded op records of the load unit
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

package core_types_pkg;

	// --------------------------------------------------
	// load op, RISC-V funct3 of the load group

	typedef enum logic [3:0] {
		LB  = 4'b0000,
		LH  = 4'b0001,
		LW  = 4'b0010,
		LBU = 4'b0100,
		LHU = 4'b0101
	} ldu_op_t;

	// where operand A comes from
	typedef enum logic [1:0] {
		SRC_REG,
		SRC_BUS,
		SRC_FAST
	} op_src_t;

	// --------------------------------------------------
	// op as it leaves the issue queue

	typedef struct packed {
		ldu_op_t op;
		logic [11:0] imm12;
		op_src_t src;
		logic [`LOG_FAST_FORWARD_PIPE_COUNT-1:0] pipe;
		logic [`LOG_PRF_BANK_COUNT-1:0] bank;
		logic [`LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_issue_t;

	// op held in the operand collector
	// size is in bytes, 1, 2 or 4
	typedef struct packed {
		logic [2:0] size;
		op_src_t src;
		logic [`LOG_FAST_FORWARD_PIPE_COUNT-1:0] pipe;
		logic [`LOG_PRF_BANK_COUNT-1:0] bank;
		logic [11:0] imm12;
		logic [`LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_decoded_t;

endpackage

`default_nettype wire

//--- common/system_types_pkg.sv
// --------------------------------------------------
// system types
// virtual address split and data cache request
// --------------------------------------------------

`default_nettype none

`include "ldu_settings.svh"

package system_types_pkg;

	// 32-bit virtual address as the cache sees it
	typedef struct packed {
		logic [`VPN_WIDTH-1:0] vpn;
		logic [`PO_WIDTH-3:0] po_word;
		logic [1:0] byte_offset;
	} ldu_vaddr_t;

	// one word request to a data cache bank
	typedef struct packed {
		logic is_mq;
		logic misaligned;
		logic [`VPN_WIDTH-1:0] vpn;
		logic [`PO_WIDTH-3:0] po_word;
		logic [3:0] byte_mask;
		logic [`LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_req_t;

endpackage

`default_nettype wire

//--- common/ldu_settings.svh
// --------------------------------------------------
// load unit settings
// widths and counts shared by the address pipeline
// --------------------------------------------------

`ifndef LDU_SETTINGS_SVH
`define LDU_SETTINGS_SVH

// completion queue
`define LDU_CQ_ENTRIES 8
`define LOG_LDU_CQ_ENTRIES 3

// register file banks, one forward bus each
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT 2

// width of the fast-forward pipe index carried by an issued op
`define LOG_FAST_FORWARD_PIPE_COUNT 2

// 32-bit virtual address split
`define VPN_WIDTH 20
`define PO_WIDTH 12

`endif
